// File: rtl/core_config.svh
// core word width, register count and reset pc
`ifndef CORE_CONFIG_SVH
`define CORE_CONFIG_SVH

// data path and register width
`define CORE_DATA_WIDTH 32

// architectural registers, x0 included
`define CORE_REG_COUNT 32

// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: rtl/isa_pkg.sv
// rv32i subset opcodes, funct codes, instruction formats and alu operations
`include "core_config.svh"

package isa_pkg;

    localparam int reg_idx_w = $clog2(`CORE_REG_COUNT);

    typedef logic [reg_idx_w-1:0] reg_idx_t;

    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_branch = 7'b1100011;

    localparam logic [2:0] f3_add_sub = 3'b000;
    localparam logic [2:0] f3_slt     = 3'b010;
    localparam logic [2:0] f3_xor     = 3'b100;
    localparam logic [2:0] f3_or      = 3'b110;
    localparam logic [2:0] f3_and     = 3'b111;
    // width field of loads and stores
    localparam logic [2:0] f3_byte    = 3'b000;
    localparam logic [2:0] f3_word    = 3'b010;
    localparam logic [2:0] f3_beq     = 3'b000;
    localparam logic [2:0] f3_bne     = 3'b001;

    localparam logic [6:0] f7_sub = 7'b0100000;

    typedef struct packed {
        logic [6:0] funct7;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        reg_idx_t   rd;
        logic [6:0] opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0] imm;
        reg_idx_t    rs1;
        logic [2:0]  funct3;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } s_fmt_t;

    // branch offset bits are scattered, bit 0 is implied zero
    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        reg_idx_t   rs2;
        reg_idx_t   rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_fmt_t;

    typedef struct packed {
        logic [19:0] imm;
        reg_idx_t    rd;
        logic [6:0]  opcode;
    } u_fmt_t;

    typedef union packed {
        r_fmt_t                      r;
        i_fmt_t                      i;
        s_fmt_t                      s;
        b_fmt_t                      b;
        u_fmt_t                      u;
        logic [`CORE_DATA_WIDTH-1:0] raw;
    } inst_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor,
        alu_slt,
        alu_pass_b
    } alu_op_t;

    typedef enum logic {
        wb_alu,
        wb_load
    } wb_sel_t;

endpackage

// File: rtl/pipe_pkg.sv
// pipeline stage boundary structs, forwarding source, redirect and hazard structs
`include "core_config.svh"

package pipe_pkg;

    typedef logic [`CORE_DATA_WIDTH-1:0] word_t;

    typedef struct packed {
        isa_pkg::inst_t inst;
        word_t          pc;
    } if_id_t;

    typedef struct packed {
        word_t             pc;
        word_t             rs1_val;
        word_t             rs2_val;
        word_t             imm;
        isa_pkg::reg_idx_t rs1;
        isa_pkg::reg_idx_t rs2;
        isa_pkg::reg_idx_t rd;
        isa_pkg::alu_op_t  alu_op;
        logic              use_imm;
        logic              branch;
        logic              br_ne;
        logic              dm_en;
        logic              is_byte;
        logic              is_load;
        logic              rf_en;
        isa_pkg::wb_sel_t  wb_sel;
    } id_ex_t;

    // dm_en covers loads and stores, is_load tells them apart
    typedef struct packed {
        word_t             opr_res;
        word_t             store_data;
        isa_pkg::reg_idx_t rd;
        logic              rf_en;
        logic              dm_en;
        logic              is_load;
        logic              is_byte;
        isa_pkg::wb_sel_t  wb_sel;
    } ex_mem_t;

    typedef struct packed {
        word_t             opr_res;
        word_t             lsu_rdata;
        isa_pkg::reg_idx_t rd;
        logic              rf_en;
        isa_pkg::wb_sel_t  wb_sel;
    } mem_wb_t;

    typedef struct packed {
        isa_pkg::reg_idx_t rd;
        logic              rf_en;
        word_t             value;
    } fwd_src_t;

    typedef struct packed {
        logic  br_taken;
        word_t br_target;
    } redirect_t;

    typedef struct packed {
        logic stall;
        logic flush;
    } hazard_t;

endpackage

// File: rtl/if_stage.sv
// program counter with stall hold and branch redirect
`include "core_config.svh"

module if_stage
(
    input  logic                clk,
    input  logic                arst_n,
    input  pipe_pkg::redirect_t redirect,
    input  pipe_pkg::hazard_t   hazard,
    output pipe_pkg::word_t     pc
);
    // branch wins over stall, the stalled instruction is discarded anyway
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            pc <= `CORE_RESET_PC;
        end
        else if (redirect.br_taken)
        begin
            pc <= redirect.br_target;
        end
        else if (!hazard.stall)
        begin
            pc <= pc + 4;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n) pc[1:0] == 2'b00);

endmodule

// File: rtl/id_stage.sv
// instruction decoder, register file with write-first read, load-use hazard unit
`include "core_config.svh"

module id_stage
(
    input  logic               clk,
    input  logic               arst_n,
    input  pipe_pkg::if_id_t   if_id,
    input  isa_pkg::reg_idx_t  ex_hazard_rd,
    input  logic               ex_is_load,
    input  pipe_pkg::mem_wb_t  wb,
    output pipe_pkg::id_ex_t   id_ex,
    output pipe_pkg::hazard_t  hazard,
    output pipe_pkg::fwd_src_t wb_fwd
);
    import isa_pkg::*;
    import pipe_pkg::*;

    inst_t   inst;
    word_t   imm;
    alu_op_t alu_op;
    logic    use_rs1;
    logic    use_rs2;
    logic    use_imm;
    logic    branch;
    logic    dm_en;
    logic    is_load;
    logic    rf_en;
    wb_sel_t wb_sel;
    logic    load_use;
    word_t   regs [`CORE_REG_COUNT];
    word_t   wb_data;
    logic    wb_we;
    word_t   rs1_val;
    word_t   rs2_val;

    function automatic alu_op_t alu_decode(input logic [2:0] funct3, input logic sub);
        alu_op_t op;
        case (funct3)
            f3_add_sub: op = sub ? alu_sub : alu_add;
            f3_slt:     op = alu_slt;
            f3_xor:     op = alu_xor;
            f3_or:      op = alu_or;
            f3_and:     op = alu_and;
            default:    op = alu_add;
        endcase
        return op;
    endfunction

    assign inst = if_id.inst;

    // unknown opcodes decode to a bubble
    always_comb
    begin
        imm     = '0;
        alu_op  = alu_add;
        use_rs1 = 1'b0;
        use_rs2 = 1'b0;
        use_imm = 1'b0;
        branch  = 1'b0;
        dm_en   = 1'b0;
        is_load = 1'b0;
        rf_en   = 1'b0;
        wb_sel  = wb_alu;
        case (inst.r.opcode)
            op_reg:
            begin
                {use_rs1, use_rs2, rf_en} = 3'b111;
                alu_op = alu_decode(inst.r.funct3, inst.r.funct7 == f7_sub);
            end
            op_imm:
            begin
                {use_rs1, use_imm, rf_en} = 3'b111;
                imm    = word_t'($signed(inst.i.imm));
                alu_op = alu_decode(inst.i.funct3, 1'b0);
            end
            op_lui:
            begin
                {use_imm, rf_en} = 2'b11;
                imm    = word_t'({inst.u.imm, 12'b0});
                alu_op = alu_pass_b;
            end
            op_load:
            begin
                {use_rs1, use_imm, rf_en, dm_en, is_load} = 5'b11111;
                imm    = word_t'($signed(inst.i.imm));
                wb_sel = wb_load;
            end
            op_store:
            begin
                {use_rs1, use_rs2, use_imm, dm_en} = 4'b1111;
                imm = word_t'($signed({inst.s.imm_hi, inst.s.imm_lo}));
            end
            op_branch:
            begin
                {use_rs1, use_rs2, branch} = 3'b111;
                imm = word_t'($signed({inst.b.imm_12, inst.b.imm_11, inst.b.imm_10_5,
                                       inst.b.imm_4_1, 1'b0}));
            end
            default:
            begin
            end
        endcase
    end

    assign wb_data = (wb.wb_sel == wb_load) ? wb.lsu_rdata : wb.opr_res;
    assign wb_we   = wb.rf_en && (wb.rd != '0);

    // x0 keeps its reset value, writes to it are dropped
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
        begin
            regs <= '{default: '0};
        end
        else if (wb_we)
        begin
            regs[wb.rd] <= wb_data;
        end
    end

    // same-cycle writeback bypasses the array
    assign rs1_val = (wb_we && wb.rd == inst.r.rs1) ? wb_data : regs[inst.r.rs1];
    assign rs2_val = (wb_we && wb.rd == inst.r.rs2) ? wb_data : regs[inst.r.rs2];

    assign wb_fwd.rd    = wb.rd;
    assign wb_fwd.rf_en = wb.rf_en;
    assign wb_fwd.value = wb_data;

    // unused source indices are zeroed so EX never forwards into them
    always_comb
    begin
        id_ex.pc      = if_id.pc;
        id_ex.rs1_val = rs1_val;
        id_ex.rs2_val = rs2_val;
        id_ex.imm     = imm;
        id_ex.rs1     = use_rs1 ? inst.r.rs1 : '0;
        id_ex.rs2     = use_rs2 ? inst.r.rs2 : '0;
        id_ex.rd      = rf_en ? inst.r.rd : '0;
        id_ex.alu_op  = alu_op;
        id_ex.use_imm = use_imm;
        id_ex.branch  = branch;
        id_ex.br_ne   = (inst.b.funct3 == f3_bne);
        id_ex.dm_en   = dm_en;
        id_ex.is_byte = (inst.i.funct3 == f3_byte);
        id_ex.is_load = is_load;
        id_ex.rf_en   = rf_en;
        id_ex.wb_sel  = wb_sel;
    end

    assign load_use = ex_is_load && (ex_hazard_rd != '0) &&
                      ((use_rs1 && inst.r.rs1 == ex_hazard_rd) ||
                       (use_rs2 && inst.r.rs2 == ex_hazard_rd));
    assign hazard.stall = load_use;
    assign hazard.flush = load_use;

    // a load-use bubble lasts one cycle
    assert property (@(posedge clk) disable iff (!arst_n) hazard.stall |=> !hazard.stall);
    assert property (@(posedge clk) disable iff (!arst_n)
        (inst.r.rs1 == '0) |-> (rs1_val == '0));

endmodule

// File: rtl/ex_stage.sv
// operand forwarding, alu, branch compare and target
module ex_stage
(
    input  pipe_pkg::id_ex_t    id_ex,
    input  pipe_pkg::fwd_src_t  mem_fwd,
    input  pipe_pkg::fwd_src_t  wb_fwd,
    output pipe_pkg::ex_mem_t   ex_mem,
    output pipe_pkg::redirect_t redirect
);
    import isa_pkg::*;
    import pipe_pkg::*;

    word_t rs1_fwd;
    word_t rs2_fwd;
    word_t op_b;
    word_t alu_res;
    logic  is_eq;

    // mem is younger than wb, so it is checked first
    function automatic word_t fwd_pick(input reg_idx_t idx, input word_t rf_val,
                                       input fwd_src_t m, input fwd_src_t w);
        word_t val;
        if (idx != '0 && m.rf_en && m.rd == idx)
            val = m.value;
        else if (idx != '0 && w.rf_en && w.rd == idx)
            val = w.value;
        else
            val = rf_val;
        return val;
    endfunction

    assign rs1_fwd = fwd_pick(id_ex.rs1, id_ex.rs1_val, mem_fwd, wb_fwd);
    assign rs2_fwd = fwd_pick(id_ex.rs2, id_ex.rs2_val, mem_fwd, wb_fwd);
    assign op_b    = id_ex.use_imm ? id_ex.imm : rs2_fwd;

    always_comb
    begin
        case (id_ex.alu_op)
            alu_add:    alu_res = rs1_fwd + op_b;
            alu_sub:    alu_res = rs1_fwd - op_b;
            alu_and:    alu_res = rs1_fwd & op_b;
            alu_or:     alu_res = rs1_fwd | op_b;
            alu_xor:    alu_res = rs1_fwd ^ op_b;
            alu_slt:    alu_res = word_t'($signed(rs1_fwd) < $signed(op_b));
            alu_pass_b: alu_res = op_b;
            default:    alu_res = rs1_fwd + op_b;
        endcase
    end

    always_comb
    begin
        is_eq              = (rs1_fwd == rs2_fwd);
        redirect.br_taken  = id_ex.branch && (id_ex.br_ne ? !is_eq : is_eq);
        redirect.br_target = id_ex.pc + id_ex.imm;
        assert (!redirect.br_taken || redirect.br_target[1:0] == 2'b00)
            else $error("taken branch to a misaligned target");
    end

    assign ex_mem.opr_res    = alu_res;
    assign ex_mem.store_data = rs2_fwd;
    assign ex_mem.rd         = id_ex.rd;
    assign ex_mem.rf_en      = id_ex.rf_en;
    assign ex_mem.dm_en      = id_ex.dm_en;
    assign ex_mem.is_load    = id_ex.is_load;
    assign ex_mem.is_byte    = id_ex.is_byte;
    assign ex_mem.wb_sel     = id_ex.wb_sel;

endmodule

// File: rtl/mem_stage.sv
// store mask and byte replication, load byte select with sign extension
module mem_stage
(
    input  pipe_pkg::ex_mem_t mem_in,
    input  pipe_pkg::word_t   mem_data_out,
    output pipe_pkg::word_t   mem_addr_in,
    output pipe_pkg::word_t   mem_data_in,
    output logic              mem_we_in,
    output logic [3:0]        mem_mask_in,
    output pipe_pkg::mem_wb_t mem_wb
);
    import pipe_pkg::*;

    word_t      lane;
    logic [7:0] load_byte;

    assign mem_addr_in = mem_in.opr_res;
    assign mem_data_in = mem_in.is_byte ? {4{mem_in.store_data[7:0]}} : mem_in.store_data;

    always_comb
    begin
        mem_we_in   = mem_in.dm_en && !mem_in.is_load;
        mem_mask_in = mem_in.is_byte ? (4'b0001 << mem_in.opr_res[1:0]) : 4'b1111;
        assert (!mem_we_in || mem_in.is_byte || mem_in.opr_res[1:0] == 2'b00)
            else $error("word store to a misaligned address");
    end

    // shift the addressed byte down to lane 0
    assign lane      = mem_data_out >> {mem_in.opr_res[1:0], 3'b000};
    assign load_byte = lane[7:0];

    assign mem_wb.opr_res   = mem_in.opr_res;
    assign mem_wb.lsu_rdata = mem_in.is_byte ? word_t'($signed(load_byte)) : mem_data_out;
    assign mem_wb.rd        = mem_in.rd;
    assign mem_wb.rf_en     = mem_in.rf_en;
    assign mem_wb.wb_sel    = mem_in.wb_sel;

endmodule

// File: rtl/core.sv
// five-stage core top with stage instances and pipeline registers
module core
(
    input  logic            clk,
    input  logic            arst_n,
    output pipe_pkg::word_t pc,
    input  pipe_pkg::word_t inst_in,
    input  pipe_pkg::word_t mem_data_out,
    output pipe_pkg::word_t mem_addr_in,
    output pipe_pkg::word_t mem_data_in,
    output logic            mem_we_in,
    output logic [3:0]      mem_mask_in
);
    import pipe_pkg::*;

    if_id_t    if_id_d;
    if_id_t    if_id_q;
    id_ex_t    id_ex_d;
    id_ex_t    id_ex_q;
    ex_mem_t   ex_mem_d;
    ex_mem_t   ex_mem_q;
    mem_wb_t   mem_wb_d;
    mem_wb_t   mem_wb_q;
    redirect_t redirect;
    hazard_t   hazard;
    fwd_src_t  mem_fwd;
    fwd_src_t  wb_fwd;

    if_stage i_if_stage (
        .clk      (clk     ),
        .arst_n   (arst_n  ),
        .redirect (redirect),
        .hazard   (hazard  ),
        .pc       (pc      )
    );

    assign if_id_d.inst = inst_in;
    assign if_id_d.pc   = pc;

    id_stage i_id_stage (
        .clk          (clk            ),
        .arst_n       (arst_n         ),
        .if_id        (if_id_q        ),
        .ex_hazard_rd (id_ex_q.rd     ),
        .ex_is_load   (id_ex_q.is_load),
        .wb           (mem_wb_q       ),
        .id_ex        (id_ex_d        ),
        .hazard       (hazard         ),
        .wb_fwd       (wb_fwd         )
    );

    // only the alu result is forwarded from mem
    assign mem_fwd.rd    = ex_mem_q.rd;
    assign mem_fwd.rf_en = ex_mem_q.rf_en;
    assign mem_fwd.value = ex_mem_q.opr_res;

    ex_stage i_ex_stage (
        .id_ex    (id_ex_q ),
        .mem_fwd  (mem_fwd ),
        .wb_fwd   (wb_fwd  ),
        .ex_mem   (ex_mem_d),
        .redirect (redirect)
    );

    mem_stage i_mem_stage (
        .mem_in       (ex_mem_q    ),
        .mem_data_out (mem_data_out),
        .mem_addr_in  (mem_addr_in ),
        .mem_data_in  (mem_data_in ),
        .mem_we_in    (mem_we_in   ),
        .mem_mask_in  (mem_mask_in ),
        .mem_wb       (mem_wb_d    )
    );

    // if -> id, holds on load-use stall
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            if_id_q <= '0;
        else if (redirect.br_taken)
            if_id_q <= '0;
        else if (!hazard.stall)
            if_id_q <= if_id_d;
    end

    // id -> ex, bubble on load-use or taken branch
    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            id_ex_q <= '0;
        else if (hazard.flush || redirect.br_taken)
            id_ex_q <= '0;
        else
            id_ex_q <= id_ex_d;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            ex_mem_q <= '0;
        else
            ex_mem_q <= ex_mem_d;
    end

    always_ff @(posedge clk or negedge arst_n)
    begin
        if (!arst_n)
            mem_wb_q <= '0;
        else
            mem_wb_q <= mem_wb_d;
    end

    assert property (@(posedge clk) disable iff (!arst_n) !$isunknown(mem_we_in));

endmodule

// File: tests/tb_memory.sv
// instruction rom and byte-addressed data ram with a write log
module tb_memory
(
    input  logic        clk,
    input  logic [31:0] pc,
    output logic [31:0] inst,
    input  logic [31:0] addr,
    input  logic [31:0] wdata,
    input  logic        we,
    input  logic [3:0]  mask,
    output logic [31:0] rdata
);
    timeunit 1ns;
    timeprecision 100ps;

    // written by the test before reset is released
    logic [31:0] rom [256];
    logic [31:0] ram [256];

    logic [31:0] log_addr [$];
    logic [3:0]  log_mask [$];
    logic [31:0] log_data [$];

    initial
    begin
        for (int i = 0; i < 256; i++)
        begin
            ram[i] <= {8'ha5, i[7:0], ~i[7:0], i[7:0]};
        end
    end

    assign inst  = rom[pc[9:2]];
    assign rdata = ram[addr[9:2]];

    always @(posedge clk)
    begin
        if (we)
        begin
            for (int b = 0; b < 4; b++)
            begin
                if (mask[b])
                begin
                    ram[addr[9:2]][8*b +: 8] <= wdata[8*b +: 8];
                end
            end
            log_addr.push_back(addr);
            log_mask.push_back(mask);
            log_data.push_back(wdata);
        end
    end

endmodule

// File: tests/core_tb.sv
// core testbench with program builder, instruction-level model and store checks
`include "core_config.svh"

module core_tb;
    timeunit 1ns;
    timeprecision 100ps;

    import isa_pkg::*;

    localparam logic [31:0] poison_addr = 32'h0000_03f0;
    localparam logic [31:0] done_addr   = 32'h0000_03f8;

    logic        clk = 1'b0;
    logic        arst_n;
    logic [31:0] pc;
    logic [31:0] inst_in;
    logic [31:0] mem_data_out;
    logic [31:0] mem_addr_in;
    logic [31:0] mem_data_in;
    logic        mem_we_in;
    logic [3:0]  mem_mask_in;

    logic [31:0] mreg [32];
    logic [31:0] mmem [256];
    logic [31:0] exp_addr [128];
    logic [3:0]  exp_mask [128];
    logic [31:0] exp_data [128];
    int          n_exp = 0;
    int          exp_idx = 0;
    int          pc_n = 0;
    int          slot = 0;
    logic        done = 1'b0;
    int          err_store = 0;
    int          err_poison = 0;
    int          err_reset = 0;
    int          err_misc = 0;

    always #50 clk = ~clk;

    core dut0 (
        .clk          (clk         ),
        .arst_n       (arst_n      ),
        .pc           (pc          ),
        .inst_in      (inst_in     ),
        .mem_data_out (mem_data_out),
        .mem_addr_in  (mem_addr_in ),
        .mem_data_in  (mem_data_in ),
        .mem_we_in    (mem_we_in   ),
        .mem_mask_in  (mem_mask_in )
    );

    tb_memory mem0 (
        .clk   (clk         ),
        .pc    (pc          ),
        .inst  (inst_in     ),
        .addr  (mem_addr_in ),
        .wdata (mem_data_in ),
        .we    (mem_we_in   ),
        .mask  (mem_mask_in ),
        .rdata (mem_data_out)
    );

    function automatic logic [31:0] sext12(input logic [11:0] v);
        return {{20{v[11]}}, v};
    endfunction

    // reference alu from the isa rules
    function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic sub,
                                              input logic [31:0] a, input logic [31:0] b);
        logic [31:0] r;
        case (f3)
            f3_add_sub: r = sub ? a - b : a + b;
            f3_slt:     r = {31'b0, $signed(a) < $signed(b)};
            f3_xor:     r = a ^ b;
            f3_or:      r = a | b;
            default:    r = a & b;
        endcase
        return r;
    endfunction

    function automatic logic [31:0] enc_r(input logic [2:0] f3, input logic [6:0] f7,
                                          input reg_idx_t rd, input reg_idx_t rs1,
                                          input reg_idx_t rs2);
        inst_t w;
        w.r.funct7 = f7;
        w.r.rs2    = rs2;
        w.r.rs1    = rs1;
        w.r.funct3 = f3;
        w.r.rd     = rd;
        w.r.opcode = op_reg;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                          input logic [2:0] f3, input reg_idx_t rd,
                                          input logic [6:0] op);
        inst_t w;
        w.i.imm    = imm;
        w.i.rs1    = rs1;
        w.i.funct3 = f3;
        w.i.rd     = rd;
        w.i.opcode = op;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        inst_t w;
        w.s.imm_hi = imm[11:5];
        w.s.rs2    = rs2;
        w.s.rs1    = rs1;
        w.s.funct3 = f3;
        w.s.imm_lo = imm[4:0];
        w.s.opcode = op_store;
        return w.raw;
    endfunction

    function automatic logic [31:0] enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                          input reg_idx_t rs1, input logic [2:0] f3);
        inst_t w;
        w.b.imm_12   = imm[12];
        w.b.imm_10_5 = imm[10:5];
        w.b.rs2      = rs2;
        w.b.rs1      = rs1;
        w.b.funct3   = f3;
        w.b.imm_4_1  = imm[4:1];
        w.b.imm_11   = imm[11];
        w.b.opcode   = op_branch;
        return w.raw;
    endfunction

    task automatic put(input logic [31:0] w);
        mem0.rom[pc_n] = w;
        pc_n++;
    endtask

    task automatic wr_reg(input reg_idx_t rd, input logic [31:0] v);
        if (rd != 0)
            mreg[rd] = v;
    endtask

    task automatic do_r(input logic [2:0] f3, input logic sub, input reg_idx_t rd,
                        input reg_idx_t rs1, input reg_idx_t rs2);
        put(enc_r(f3, sub ? f7_sub : 7'b0, rd, rs1, rs2));
        wr_reg(rd, alu_model(f3, sub, mreg[rs1], mreg[rs2]));
    endtask

    task automatic do_i(input logic [2:0] f3, input reg_idx_t rd, input reg_idx_t rs1,
                        input logic [11:0] imm);
        put(enc_i(imm, rs1, f3, rd, op_imm));
        wr_reg(rd, alu_model(f3, 1'b0, mreg[rs1], sext12(imm)));
    endtask

    task automatic do_lui(input reg_idx_t rd, input logic [19:0] imm);
        inst_t w;
        w.u.imm    = imm;
        w.u.rd     = rd;
        w.u.opcode = op_lui;
        put(w.raw);
        wr_reg(rd, {imm, 12'b0});
    endtask

    task automatic do_store(input logic is_byte, input reg_idx_t rs2, input reg_idx_t rs1,
                            input logic [11:0] imm);
        logic [31:0] a;
        logic [3:0]  m;
        logic [31:0] d;
        a = mreg[rs1] + sext12(imm);
        m = is_byte ? 4'b0001 << a[1:0] : 4'b1111;
        d = is_byte ? {4{mreg[rs2][7:0]}} : mreg[rs2];
        for (int b = 0; b < 4; b++)
        begin
            if (m[b])
                mmem[a[9:2]][8*b +: 8] = d[8*b +: 8];
        end
        put(enc_s(imm, rs2, rs1, is_byte ? f3_byte : f3_word));
        exp_addr[n_exp] = a;
        exp_mask[n_exp] = m;
        exp_data[n_exp] = d;
        n_exp++;
    endtask

    task automatic do_load(input logic is_byte, input reg_idx_t rd, input reg_idx_t rs1,
                           input logic [11:0] imm);
        logic [31:0] a;
        logic [31:0] wd;
        a  = mreg[rs1] + sext12(imm);
        wd = mmem[a[9:2]] >> {a[1:0], 3'b000};
        put(enc_i(imm, rs1, is_byte ? f3_byte : f3_word, rd, op_load));
        wr_reg(rd, is_byte ? {{24{wd[7]}}, wd[7:0]} : mmem[a[9:2]]);
    endtask

    // results go to consecutive words above x1
    task automatic save(input reg_idx_t rs);
        do_store(1'b0, rs, 5'd1, 12'(4 * slot));
        slot++;
    endtask

    // offset 12 skips the two slots after the branch
    task automatic do_branch(input logic ne, input reg_idx_t rs1, input reg_idx_t rs2);
        logic taken;
        taken = ne ? (mreg[rs1] != mreg[rs2]) : (mreg[rs1] == mreg[rs2]);
        put(enc_b(13'd12, rs2, rs1, ne ? f3_bne : f3_beq));
        if (taken)
        begin
            put(enc_s(12'd0, 5'd4, 5'd2, f3_word));
            put(enc_s(12'd0, 5'd5, 5'd2, f3_word));
        end
        else
        begin
            save(5'd4);
            save(5'd5);
        end
    endtask

    task automatic build_program();
        logic [11:0] bv;
        for (int i = 0; i < 256; i++)
            mem0.rom[i] = enc_i(i[11:0], 5'd0, f3_add_sub, 5'd0, op_imm);
        mreg[0] = '0;
        do_i(f3_add_sub, 5'd1, 5'd0, 12'h100);
        do_i(f3_add_sub, 5'd2, 5'd0, poison_addr[11:0]);
        do_i(f3_add_sub, 5'd3, 5'd0, done_addr[11:0]);
        do_lui(5'd4, 20'($urandom));
        do_i(f3_add_sub, 5'd4, 5'd4, 12'($urandom));
        save(5'd4);
        do_lui(5'd5, 20'($urandom));
        do_i(f3_add_sub, 5'd5, 5'd5, 12'($urandom));
        save(5'd5);
        do_r(f3_add_sub, 1'b0, 5'd6, 5'd4, 5'd5);
        save(5'd6);
        do_r(f3_add_sub, 1'b1, 5'd7, 5'd4, 5'd5);
        save(5'd7);
        do_r(f3_and, 1'b0, 5'd8, 5'd4, 5'd5);
        save(5'd8);
        do_r(f3_or, 1'b0, 5'd9, 5'd4, 5'd5);
        save(5'd9);
        do_r(f3_xor, 1'b0, 5'd6, 5'd4, 5'd5);
        save(5'd6);
        do_r(f3_slt, 1'b0, 5'd7, 5'd4, 5'd5);
        save(5'd7);
        do_r(f3_slt, 1'b0, 5'd8, 5'd5, 5'd4);
        save(5'd8);
        do_i(f3_add_sub, 5'd6, 5'd4, 12'($urandom));
        save(5'd6);
        do_i(f3_and, 5'd7, 5'd4, 12'($urandom));
        save(5'd7);
        do_i(f3_or, 5'd8, 5'd5, 12'($urandom));
        save(5'd8);
        do_i(f3_xor, 5'd9, 5'd5, 12'($urandom));
        save(5'd9);
        // dependent chains, mem then wb forwarding
        do_r(f3_add_sub, 1'b0, 5'd10, 5'd4, 5'd5);
        do_r(f3_add_sub, 1'b0, 5'd11, 5'd10, 5'd10);
        do_i(f3_add_sub, 5'd12, 5'd4, 12'($urandom));
        do_r(f3_add_sub, 1'b0, 5'd13, 5'd11, 5'd12);
        save(5'd13);
        do_i(f3_add_sub, 5'd0, 5'd4, 12'($urandom));
        do_r(f3_add_sub, 1'b0, 5'd14, 5'd0, 5'd5);
        save(5'd14);
        // load-use
        save(5'd13);
        do_load(1'b0, 5'd15, 5'd1, 12'(4 * (slot - 1)));
        do_r(f3_add_sub, 1'b0, 5'd16, 5'd15, 5'd4);
        save(5'd16);
        // byte stores at all four lanes, then a signed byte load
        do_i(f3_add_sub, 5'd17, 5'd0, 12'h200);
        bv = 12'($urandom) | 12'h080;
        do_i(f3_add_sub, 5'd18, 5'd0, bv);
        for (int b = 0; b < 4; b++)
        begin
            do_store(1'b1, 5'd18, 5'd17, 12'(b));
            do_i(f3_add_sub, 5'd18, 5'd18, 12'h011);
        end
        do_load(1'b1, 5'd19, 5'd17, 12'd0);
        save(5'd19);
        do_load(1'b0, 5'd20, 5'd17, 12'd0);
        save(5'd20);
        do_branch(1'b0, 5'd4, 5'd4);
        do_branch(1'b0, 5'd4, 5'd5);
        do_branch(1'b1, 5'd4, 5'd5);
        do_branch(1'b1, 5'd5, 5'd5);
        do_store(1'b0, 5'd4, 5'd3, 12'd0);
    endtask

    always @(posedge clk)
    begin
        if (arst_n && mem_we_in)
        begin
            exp_idx <= exp_idx + 1;
            if (mem_addr_in == done_addr)
                done <= 1'b1;
        end
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_we_in |-> (exp_idx < n_exp && mem_addr_in == exp_addr[exp_idx] &&
                       mem_data_in == exp_data[exp_idx] && mem_mask_in == exp_mask[exp_idx]))
    else
    begin
        err_store = err_store + 1;
        $display("** Error store %0d: mem_addr_in=%h mem_data_in=%h mem_mask_in=%h", exp_idx,
                 $sampled(mem_addr_in), $sampled(mem_data_in), $sampled(mem_mask_in));
    end

    assert property (@(posedge clk) disable iff (!arst_n)
        mem_we_in |-> mem_addr_in != poison_addr)
    else
    begin
        err_poison = err_poison + 1;
        $display("an instruction after a taken branch wrote the poison address");
    end

    assert property (@(posedge clk)
        (!arst_n || $past(!arst_n)) |-> (pc == `CORE_RESET_PC && !mem_we_in))
    else
    begin
        err_reset = err_reset + 1;
        $display("pc or mem_we_in not in reset state during or right after reset");
    end

    initial
    begin
        int cycles;
        int total;
        arst_n <= 1'b0;
        void'($urandom(32'h1c1defe4));
        build_program();
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        cycles = 0;
        while (!done && cycles < 2000)
        begin
            @(posedge clk);
            cycles++;
        end
        if (!done)
        begin
            $display("timeout waiting for the store to the done address");
            err_misc++;
        end
        repeat (4) @(posedge clk);
        if (mem0.log_addr.size() != n_exp)
        begin
            $display("write log holds %0d stores, the model expects %0d",
                     mem0.log_addr.size(), n_exp);
            err_misc++;
        end
        for (int k = 0; k < mem0.log_addr.size() && k < n_exp; k++)
        begin
            if (mem0.log_addr[k] != exp_addr[k] || mem0.log_mask[k] != exp_mask[k] ||
                mem0.log_data[k] != exp_data[k])
            begin
                $display("write log entry %0d differs from the expected store", k);
                err_misc++;
            end
        end
        total = err_store + err_poison + err_reset + err_misc;
        $display("errors %0d: store %0d, poison %0d, reset %0d, other %0d",
                 total, err_store, err_poison, err_reset, err_misc);
        if (total == 0)
            $display("All checks passed");
        else
            $display("Checks failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+rtl
rtl/isa_pkg.sv
rtl/pipe_pkg.sv
rtl/if_stage.sv
rtl/id_stage.sv
rtl/ex_stage.sv
rtl/mem_stage.sv
rtl/core.sv
tests/tb_memory.sv
tests/core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the core testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module core_tb -o core_tb_sim
if [ $? -ne 0 ]; then
    echo "build failed"
    exit 1
fi

out=$(./obj_dir/core_tb_sim)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$out" | grep -qx "All checks passed"; then
    exit 0
fi
exit 1
